// ==== src/mem_if.sv ====
// Internal valid/ready channels
// Request and response streams between the subsystem blocks

`default_nettype none

// Request channel
interface mem_req_if;
    logic               valid;
    logic               ready;
    sram_pkg::mem_req_t data;

    modport src (output valid, output data, input ready);
    modport snk (input valid, input data, output ready);
endinterface

// Response channel
interface mem_rsp_if;
    logic               valid;
    logic               ready;
    sram_pkg::mem_rsp_t data;

    modport src (output valid, output data, input ready);
    modport snk (input valid, input data, output ready);
endinterface

`default_nettype wire

// ==== src/req_decoder.sv ====
// Request address decoder
// Steers requests to the SRAM sequencer or answers unmapped ones with an error

`default_nettype none

`include "sram_config.svh"

module req_decoder (
    input logic clk,
    input logic arst_n,
    mem_req_if.snk up,
    mem_req_if.src to_seq,
    mem_rsp_if.src unmapped
);

    logic hit;
    logic unm_valid;

    // ----------------------------------------
    // Window decode
    // ----------------------------------------

    // Top address byte selects the SRAM
    assign hit = (up.data.addr[`BUS_ADDR_W-1 -: 8] == `SRAM_WINDOW);

    // Mapped requests pass straight through to the sequencer
    assign to_seq.valid = up.valid && hit;
    assign to_seq.data  = up.data;

    // Ready follows whichever target the address picks
    // Unmapped side takes one completion at a time
    // and waits for an empty sequencer so responses stay in order
    assign up.ready = hit ? to_seq.ready : (!unm_valid && to_seq.ready);

    // ----------------------------------------
    // Unmapped completion
    // ----------------------------------------

    // Write data is dropped, only the error goes back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unm_valid <= 1'b0;
        end else begin
            if (up.valid && up.ready && !hit) begin
                unm_valid <= 1'b1;
            end else if (unmapped.ready) begin
                unm_valid <= 1'b0;
            end
        end
    end

    assign unmapped.valid      = unm_valid;
    // Error response carries no data
    assign unmapped.data.rdata = 32'h0;
    assign unmapped.data.err   = 1'b1;

endmodule

`default_nettype wire

// ==== src/rsp_merge.sv ====
// Response merger
// Fixed-priority arbiter, sequencer first, with a grant held under back-pressure

`default_nettype none

module rsp_merge (
    input logic clk,
    input logic arst_n,
    mem_rsp_if.snk seq,
    mem_rsp_if.snk unmapped,
    mem_rsp_if.src out
);

    logic lock_q;
    logic lock_unm_q;
    logic pick_unm;

    // ----------------------------------------
    // Grant
    // ----------------------------------------

    // Held grant wins, else sequencer unless it has nothing
    assign pick_unm = lock_q ? lock_unm_q : !seq.valid;

    assign out.valid = pick_unm ? unmapped.valid : seq.valid;
    assign out.data  = pick_unm ? unmapped.data : seq.data;

    // Sequencer only blocked by a grant held on the unmapped side
    assign seq.ready      = out.ready && !(lock_q && lock_unm_q);
    assign unmapped.ready = out.ready && pick_unm;

    // Freeze the choice while the output stalls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lock_q     <= 1'b0;
            lock_unm_q <= 1'b0;
        end else begin
            if (out.valid && out.ready) begin
                lock_q <= 1'b0;
            end else if (out.valid) begin
                lock_q     <= 1'b1;
                lock_unm_q <= pick_unm;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sram_byte_sequencer.sv ====
// Byte-serial SRAM sequencer
// Splits one 32-bit request into four 8-bit async SRAM cycles

`default_nettype none

`include "sram_config.svh"

module sram_byte_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    mem_req_if.snk                  req,
    mem_rsp_if.src                  rsp,
    output logic [`SRAM_ADDR_W-1:0] ram_addr,
    inout  wire  [7:0]              ram_data,
    output logic                    ram_nce,
    output logic                    ram_noe,
    output logic                    ram_nwe
);

    logic                    busy;
    logic                    done;
    logic [2:0]              cyc;
    logic [2:0]              last_cyc;
    logic                    is_wr;
    logic [`SRAM_ADDR_W-1:0] addr_q;
    logic [31:0]             wdata_q;
    logic [3:0]              strb_q;
    logic [7:0]              wbyte_q;
    logic [7:0]              cap_q;
    logic [23:0]             asm_q;

    // Idle and holding no result
    assign req.ready = !busy && !done;

    // Read needs one more cycle to move the last byte out
    assign last_cyc = is_wr ? 3'd4 : 3'd5;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            cyc     <= 3'd0;
            ram_nce <= 1'b1;
            ram_noe <= 1'b1;
            ram_nwe <= 1'b1;
        end else begin
            if (req.valid && req.ready) begin
                busy <= 1'b1;
                cyc  <= 3'd0;
            end else if (busy) begin
                cyc <= cyc + 3'd1;
                if (cyc == last_cyc) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (done && rsp.ready) begin
                done <= 1'b0;
            end
            // Pins lag the counter by one cycle, lanes 0..3
            if (busy && cyc < 3'd4) begin
                ram_nce <= 1'b0;
                ram_noe <= is_wr;
                ram_nwe <= !(is_wr && strb_q[cyc[1:0]]);
            end else begin
                ram_nce <= 1'b1;
                ram_noe <= 1'b1;
                ram_nwe <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            addr_q  <= req.data.addr[`SRAM_ADDR_W-1:0];
            wdata_q <= req.data.wdata;
            strb_q  <= req.data.wstrb;
            is_wr   <= |req.data.wstrb;
        end
        if (busy && cyc < 3'd4) begin
            ram_addr <= addr_q + `SRAM_ADDR_W'(cyc[1:0]);
            wbyte_q  <= wdata_q[8*cyc[1:0] +: 8];
        end
        // Bus sampled while lane 0..3 is on the pins
        if (busy && cyc >= 3'd1 && cyc <= 3'd4) begin
            cap_q <= ram_data;
        end
        // Previous capture moves into the low three bytes
        if (busy && cyc >= 3'd2 && cyc <= 3'd4) begin
            asm_q[8*(cyc - 3'd2) +: 8] <= cap_q;
        end
    end

    // Drive the bus only during a write strobe
    assign ram_data = ram_nwe ? 8'hzz : wbyte_q;

    assign rsp.valid      = done;
    assign rsp.data.rdata = is_wr ? 32'h0 : {cap_q, asm_q};
    assign rsp.data.err   = 1'b0;

endmodule

`default_nettype wire

// ==== src/sram_config.svh ====
// SRAM subsystem configuration
// Address widths and the decoded window for the external byte-wide SRAM

`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// ----------------------------------------
// Host bus
// ----------------------------------------

// Request address width on the host side
`define BUS_ADDR_W 32

// Address bits 31..24 must match this to reach the SRAM
`define SRAM_WINDOW 8'h00

// ----------------------------------------
// External SRAM
// ----------------------------------------

// 512K x 8, byte addressed
`define SRAM_ADDR_W 19

`endif

// ==== src/sram_pkg.sv ====
// SRAM subsystem types
// Request and response payloads shared by all blocks

`default_nettype none

`include "sram_config.svh"

package sram_pkg;

    // One word request from the host
    // All strobes clear means read
    typedef struct packed {
        logic [`BUS_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
    } mem_req_t;

    // One response, read data is zero for writes and errors
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== src/sram_subsystem_top.sv ====
// SRAM subsystem top level
// 32-bit valid/ready slave in front of a 512K x 8 async SRAM

`default_nettype none

`include "sram_config.svh"

module sram_subsystem_top (
    input  logic                    clk,
    input  logic                    arst_n,
    // Request channel
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [`BUS_ADDR_W-1:0]  req_addr,
    input  logic [31:0]             req_wdata,
    input  logic [3:0]              req_wstrb,
    // Response channel
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [31:0]             rsp_rdata,
    output logic                    rsp_err,
    // SRAM pins
    output logic [`SRAM_ADDR_W-1:0] ram_addr,
    inout  wire  [7:0]              ram_data,
    output logic                    ram_nce,
    output logic                    ram_noe,
    output logic                    ram_nwe
);

    sram_pkg::mem_req_t req_in;
    sram_pkg::mem_rsp_t rsp_out;

    mem_req_if slot_req_if ();
    mem_req_if seq_req_if ();
    mem_rsp_if seq_rsp_if ();
    mem_rsp_if unm_rsp_if ();
    mem_rsp_if mrg_rsp_if ();

    assign req_in.addr  = req_addr;
    assign req_in.wdata = req_wdata;
    assign req_in.wstrb = req_wstrb;

    // ----------------------------------------
    // Input side
    // ----------------------------------------

    stream_reg #(.T(sram_pkg::mem_req_t)) req_slot (
        .clk(clk), .arst_n(arst_n),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
        .out_valid(slot_req_if.valid), .out_ready(slot_req_if.ready),
        .out_data(slot_req_if.data)
    );

    req_decoder dec_i (
        .clk(clk), .arst_n(arst_n),
        .up(slot_req_if.snk), .to_seq(seq_req_if.src), .unmapped(unm_rsp_if.src)
    );

    // SRAM access
    sram_byte_sequencer seq_i (
        .clk(clk), .arst_n(arst_n),
        .req(seq_req_if.snk), .rsp(seq_rsp_if.src),
        .ram_addr(ram_addr), .ram_data(ram_data),
        .ram_nce(ram_nce), .ram_noe(ram_noe), .ram_nwe(ram_nwe)
    );

    // ----------------------------------------
    // Output side
    // ----------------------------------------

    rsp_merge merge_i (
        .clk(clk), .arst_n(arst_n),
        .seq(seq_rsp_if.snk), .unmapped(unm_rsp_if.snk), .out(mrg_rsp_if.src)
    );

    stream_reg #(.T(sram_pkg::mem_rsp_t)) rsp_slot (
        .clk(clk), .arst_n(arst_n),
        .in_valid(mrg_rsp_if.valid), .in_ready(mrg_rsp_if.ready),
        .in_data(mrg_rsp_if.data),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_out)
    );

    assign rsp_rdata = rsp_out.rdata;
    assign rsp_err   = rsp_out.err;

endmodule

`default_nettype wire

// ==== src/stream_reg.sv ====
// One-entry valid/ready register slot
// Holds a single payload of any type between two stream stages

`default_nettype none

module stream_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic full;
    logic live;
    T     data_q;

    // Input held off for the first cycle out of reset
    // Accepts when empty or when the held entry leaves this cycle
    assign in_ready = live && (!full || out_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
            full <= 1'b0;
        end else begin
            live <= 1'b1;
            if (in_valid && in_ready) begin
                full <= 1'b1;
            end else if (out_ready) begin
                full <= 1'b0;
            end
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/sram_pkg.sv
src/mem_if.sv
src/stream_reg.sv
src/req_decoder.sv
src/sram_byte_sequencer.sv
src/rsp_merge.sv
src/sram_subsystem_top.sv
verification/sram_model.sv
verification/tb_sram_subsystem.sv

// ==== verification/sram_model.sv ====
// Behavioral asynchronous SRAM, 8 bits wide
// Level-sensitive write and a combinational read onto a tristate bus

`default_nettype none

module sram_model #(
    parameter int ADDR_W = 19
) (
    input  wire [ADDR_W-1:0] addr,
    inout  wire [7:0]        data,
    input  wire              nce,
    input  wire              noe,
    input  wire              nwe
);

    logic [7:0] mem [0:(1<<ADDR_W)-1];

    // Read drives the bus only while the write strobe is idle
    assign data = (!nce && !noe && nwe) ? mem[addr] : 8'hzz;

    // Write lands once address, data and strobes have settled after a pin change
    // Pins all move on the same clock edge, so one unit later they are stable
    always @(addr or data or nce or nwe) begin
        #1;
        if (!nce && !nwe) begin
            mem[addr] = data;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_sram_subsystem.sv ====
// Testbench for the SRAM subsystem
// Random host traffic against a reference memory, checked by immediate assertions

`default_nettype none

`include "sram_config.svh"

module tb_sram_subsystem;

    localparam int          SEND_LIMIT  = 200;
    localparam int          DRAIN_LIMIT = 4000;
    localparam logic [31:0] ADDR_MASK   = (32'd1 << `SRAM_ADDR_W) - 1;

    // Expected response, data compared for reads and unmapped requests only
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
        logic        has_data;
    } expect_t;

    logic                    clk;
    logic                    arst_n;
    logic                    req_valid;
    logic                    req_ready;
    logic [`BUS_ADDR_W-1:0]  req_addr;
    logic [31:0]             req_wdata;
    logic [3:0]              req_wstrb;
    logic                    rsp_valid;
    logic                    rsp_ready;
    logic [31:0]             rsp_rdata;
    logic                    rsp_err;
    logic [`SRAM_ADDR_W-1:0] ram_addr;
    wire  [7:0]              ram_data;
    logic                    ram_nce;
    logic                    ram_noe;
    logic                    ram_nwe;

    logic [7:0]  ref_mem [int unsigned];
    expect_t     exp_q [$];
    int          errors;
    int          timeouts;
    int          max_inflight;
    int          cycles_out_of_reset;
    logic        stall_en;
    logic        held;
    logic [31:0] held_rdata;
    logic        held_err;

    sram_subsystem_top dut_i (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
        .rsp_err(rsp_err),
        .ram_addr(ram_addr), .ram_data(ram_data),
        .ram_nce(ram_nce), .ram_noe(ram_noe), .ram_nwe(ram_nwe)
    );

    sram_model #(.ADDR_W(`SRAM_ADDR_W)) sram_i (
        .addr(ram_addr), .data(ram_data), .nce(ram_nce), .noe(ram_noe), .nwe(ram_nwe)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Reference memory
    // ----------------------------------------

    // Power-up content, every address bit takes part
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_byte(a);
    endfunction

    // Random word address inside the window, span counted in words
    function automatic logic [31:0] word_addr(input int unsigned span);
        logic [16:0] idx;
        idx = $urandom % span;
        return {`SRAM_WINDOW, 5'd0, idx, 2'b00};
    endfunction

    // Strobe rule applied at the request handshake, expected response queued
    task automatic record_request(input logic [31:0] addr, input logic [31:0] wdata,
                                  input logic [3:0] wstrb);
        expect_t     e;
        logic [31:0] a;
        int          i;
        e = '0;
        if (addr[`BUS_ADDR_W-1 -: 8] != `SRAM_WINDOW) begin
            // Unmapped, memory untouched and data zero
            e.err      = 1'b1;
            e.has_data = 1'b1;
        end else begin
            for (i = 0; i < 4; i++) begin
                a = (addr + i) & ADDR_MASK;
                if (wstrb == 4'h0) begin
                    e.rdata[8*i +: 8] = ref_byte(a);
                end else if (wstrb[i]) begin
                    ref_mem[a] = wdata[8*i +: 8];
                end
            end
            e.has_data = (wstrb == 4'h0);
        end
        exp_q.push_back(e);
    endtask

    task automatic check_response();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("Response at t=%0t arrived with no request outstanding", $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            assert (rsp_err === e.err) else begin
                $display("ERROR t=%0t rsp_err expected %b got %b", $time, e.err, rsp_err);
                errors++;
            end
            if (e.has_data) begin
                assert (rsp_rdata === e.rdata) else begin
                    $display("ERROR t=%0t rsp_rdata expected %h got %h",
                             $time, e.rdata, rsp_rdata);
                    errors++;
                end
            end
        end
    endtask

    // ----------------------------------------
    // Monitors
    // ----------------------------------------

    always @(posedge clk) begin
        // SRAM pin protocol
        assert (!(ram_nce && !ram_nwe)) else begin
            $display("Write strobe low with the chip deselected at t=%0t", $time);
            errors++;
        end
        assert (!(!ram_noe && !ram_nwe)) else begin
            $display("Output enable and write strobe low together at t=%0t", $time);
            errors++;
        end
        if (ram_noe && ram_nwe) begin
            assert (ram_data === 8'hzz) else begin
                $display("ERROR t=%0t ram_data expected zz got %h", $time, ram_data);
                errors++;
            end
        end
        // Reset state, req_ready rises one cycle after release
        if (!arst_n || cycles_out_of_reset == 0) begin
            assert (rsp_valid === 1'b0 && req_ready === 1'b0) else begin
                $display("ERROR t=%0t rsp_valid/req_ready expected 00 got %b%b",
                         $time, rsp_valid, req_ready);
                errors++;
            end
            assert ({ram_nce, ram_noe, ram_nwe} === 3'b111) else begin
                $display("ERROR t=%0t ram controls expected 111 got %b",
                         $time, {ram_nce, ram_noe, ram_nwe});
                errors++;
            end
        end else if (cycles_out_of_reset == 1) begin
            assert (req_ready === 1'b1) else begin
                $display("ERROR t=%0t req_ready expected 1 got %b", $time, req_ready);
                errors++;
            end
        end
        if (arst_n) begin
            cycles_out_of_reset++;
        end
        // Stalled response must hold
        if (held) begin
            assert (rsp_valid && rsp_rdata === held_rdata && rsp_err === held_err) else begin
                $display("ERROR t=%0t rsp payload expected 1/%h/%b got %b/%h/%b", $time,
                         held_rdata, held_err, rsp_valid, rsp_rdata, rsp_err);
                errors++;
            end
        end
        held       = rsp_valid && !rsp_ready;
        held_rdata = rsp_rdata;
        held_err   = rsp_err;
        if (req_valid && req_ready) begin
            record_request(req_addr, req_wdata, req_wstrb);
        end
        if (rsp_valid && rsp_ready) begin
            check_response();
        end
    end

    always @(negedge clk) begin
        if (exp_q.size() > max_inflight) begin
            max_inflight = exp_q.size();
        end
    end

    // Random response stalls, about one cycle in four
    always @(posedge clk) begin
        rsp_ready <= stall_en ? ($urandom % 4 != 0) : 1'b1;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
        int n;
        req_valid <= 1'b1;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wstrb <= wstrb;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!req_ready && n < SEND_LIMIT);
        if (!req_ready) begin
            $display("Timeout: request to %h was never accepted", addr);
            timeouts++;
        end
        req_valid <= 1'b0;
    endtask

    // Wait for all responses, optionally with the SRAM pins held idle
    task automatic wait_drain(input logic check_idle);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (check_idle) begin
                assert ({ram_nce, ram_noe, ram_nwe} === 3'b111) else begin
                    $display("ERROR t=%0t ram controls expected 111 got %b",
                             $time, {ram_nce, ram_noe, ram_nwe});
                    errors++;
                end
            end
        end while (exp_q.size() != 0 && n < DRAIN_LIMIT);
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d responses never arrived", exp_q.size());
            timeouts++;
        end
        @(posedge clk);
    endtask

    initial begin
        int          i;
        logic [31:0] a;
        void'($urandom(24));
        clk                 = 1'b0;
        arst_n              = 1'b1;
        req_valid           = 1'b0;
        req_addr            = '0;
        req_wdata           = '0;
        req_wstrb           = '0;
        rsp_ready           = 1'b0;
        stall_en            = 1'b0;
        errors              = 0;
        timeouts            = 0;
        max_inflight        = 0;
        cycles_out_of_reset = 0;
        held                = 1'b0;
        // Reset falls at time zero and is held for five cycles
        arst_n <= 1'b0;
        for (i = 0; i < (1 << `SRAM_ADDR_W); i++) begin
            sram_i.mem[i] = fill_byte(i);
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // Full-word round trips, the read carries junk write data
        stall_en <= 1'b1;
        for (i = 0; i < 40; i++) begin
            a = word_addr(1 << 17);
            send_req(a, $urandom, 4'hf);
            send_req(a, $urandom, 4'h0);
        end
        wait_drain(1'b0);

        // Partial strobes on a small pool so bytes get rewritten
        for (i = 0; i < 40; i++) begin
            a = word_addr(32);
            send_req(a, $urandom, 4'($urandom % 16));
            send_req(a, 32'h0, 4'h0);
        end
        wait_drain(1'b0);

        // Unmapped writes alias a mapped word that must stay unchanged
        stall_en <= 1'b0;
        for (i = 0; i < 4; i++) begin
            a = word_addr(32);
            send_req({`SRAM_WINDOW + 8'd1 + 8'($urandom % 255), a[23:0]}, $urandom, 4'hf);
            wait_drain(1'b1);
            send_req(a, 32'h0, 4'h0);
            wait_drain(1'b0);
        end

        // Mixed back-to-back traffic under stalls
        stall_en <= 1'b1;
        for (i = 0; i < 80; i++) begin
            a = word_addr(16);
            if (i % 7 == 3) begin
                a[`BUS_ADDR_W-1 -: 8] = `SRAM_WINDOW + 8'd1 + 8'($urandom % 255);
            end
            send_req(a, $urandom, ($urandom % 2) ? 4'h0 : 4'($urandom % 16));
        end
        wait_drain(1'b0);

        assert (max_inflight >= 2) else begin
            $display("Back-to-back requests never had more than one in flight");
            errors++;
        end
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
